// File: logic/controlPkg.sv
package controlPkg;

    // instruction format
    localparam int InstrWidth = 32;
    localparam int OpWidth    = 5;
    localparam int OpMsb      = 31;                    // opcode sits in Ir[31:27]

    // opcodes, reference encoding
    localparam logic [OpWidth-1:0] OpLd   = 5'b00000;
    localparam logic [OpWidth-1:0] OpLdi  = 5'b00001;
    localparam logic [OpWidth-1:0] OpSt   = 5'b00010;
    localparam logic [OpWidth-1:0] OpAdd  = 5'b00011;
    localparam logic [OpWidth-1:0] OpSub  = 5'b00100;
    localparam logic [OpWidth-1:0] OpAnd  = 5'b00101;
    localparam logic [OpWidth-1:0] OpOr   = 5'b00110;
    localparam logic [OpWidth-1:0] OpRor  = 5'b00111;
    localparam logic [OpWidth-1:0] OpRol  = 5'b01000;
    localparam logic [OpWidth-1:0] OpShr  = 5'b01001;
    localparam logic [OpWidth-1:0] OpShra = 5'b01010;
    localparam logic [OpWidth-1:0] OpShl  = 5'b01011;
    localparam logic [OpWidth-1:0] OpAddi = 5'b01100;
    localparam logic [OpWidth-1:0] OpAndi = 5'b01101;
    localparam logic [OpWidth-1:0] OpOri  = 5'b01110;
    localparam logic [OpWidth-1:0] OpBr   = 5'b10011;
    localparam logic [OpWidth-1:0] OpHalt = 5'b11010;  // slot after mfhi

    // encoded alu operation
    localparam int AluWidth = 4;
    localparam logic [AluWidth-1:0] AluNone = 4'd0;
    localparam logic [AluWidth-1:0] AluAdd  = 4'd1;
    localparam logic [AluWidth-1:0] AluSub  = 4'd2;
    localparam logic [AluWidth-1:0] AluAnd  = 4'd3;
    localparam logic [AluWidth-1:0] AluOr   = 4'd4;
    localparam logic [AluWidth-1:0] AluRor  = 4'd5;
    localparam logic [AluWidth-1:0] AluRol  = 4'd6;
    localparam logic [AluWidth-1:0] AluShr  = 4'd7;
    localparam logic [AluWidth-1:0] AluShra = 4'd8;
    localparam logic [AluWidth-1:0] AluShl  = 4'd9;

    // instruction classes
    localparam int ClassWidth = 3;
    localparam logic [ClassWidth-1:0] ClsIllegal = 3'd0;
    localparam logic [ClassWidth-1:0] ClsRegAlu  = 3'd1;
    localparam logic [ClassWidth-1:0] ClsImmAlu  = 3'd2;
    localparam logic [ClassWidth-1:0] ClsLoad    = 3'd3;
    localparam logic [ClassWidth-1:0] ClsStore   = 3'd4;
    localparam logic [ClassWidth-1:0] ClsBranch  = 3'd5;
    localparam logic [ClassWidth-1:0] ClsHalt    = 3'd6;

    // steps and execute lengths
    localparam int StepWidth = 3;
    localparam logic [StepWidth-1:0] StepFetch0 = 3'd0;
    localparam logic [StepWidth-1:0] StepFetch1 = 3'd1;
    localparam logic [StepWidth-1:0] StepFetch2 = 3'd2;
    localparam logic [StepWidth-1:0] StepExec   = 3'd3;  // first execute step
    localparam logic [StepWidth-1:0] LenOne     = 3'd1;  // halt and illegal
    localparam logic [StepWidth-1:0] LenAlu     = 3'd3;
    localparam logic [StepWidth-1:0] LenMem     = 3'd5;
    localparam logic [StepWidth-1:0] LenBranch  = 3'd5;

endpackage

// File: logic/opcodeDecoder.sv
`timescale 1ns/1ns

module opcodeDecoder (
    input  logic [controlPkg::OpWidth-1:0]    OpCode,
    output logic [controlPkg::ClassWidth-1:0] InstrClass,
    output logic [controlPkg::AluWidth-1:0]   AluSel,
    output logic [controlPkg::StepWidth-1:0]  InstrLength,
    output logic                              Legal
);

    always_comb begin
        InstrClass  = controlPkg::ClsIllegal;       // unknown opcode unless matched
        AluSel      = controlPkg::AluNone;
        InstrLength = controlPkg::LenOne;           // ends after first execute step
        Legal       = 1'b0;
        case (OpCode)
            controlPkg::OpLd, controlPkg::OpLdi: begin
                InstrClass  = controlPkg::ClsLoad;
                AluSel      = controlPkg::AluAdd;   // base plus offset
                InstrLength = controlPkg::LenMem;
                Legal       = 1'b1;
            end
            controlPkg::OpSt: begin
                InstrClass  = controlPkg::ClsStore;
                AluSel      = controlPkg::AluAdd;
                InstrLength = controlPkg::LenMem;
                Legal       = 1'b1;
            end
            controlPkg::OpAdd, controlPkg::OpSub, controlPkg::OpAnd,
            controlPkg::OpOr, controlPkg::OpRor, controlPkg::OpRol,
            controlPkg::OpShr, controlPkg::OpShra, controlPkg::OpShl: begin
                InstrClass  = controlPkg::ClsRegAlu;
                InstrLength = controlPkg::LenAlu;
                Legal       = 1'b1;
                case (OpCode)
                    controlPkg::OpAdd:  AluSel = controlPkg::AluAdd;
                    controlPkg::OpSub:  AluSel = controlPkg::AluSub;
                    controlPkg::OpAnd:  AluSel = controlPkg::AluAnd;
                    controlPkg::OpOr:   AluSel = controlPkg::AluOr;
                    controlPkg::OpRor:  AluSel = controlPkg::AluRor;
                    controlPkg::OpRol:  AluSel = controlPkg::AluRol;
                    controlPkg::OpShr:  AluSel = controlPkg::AluShr;
                    controlPkg::OpShra: AluSel = controlPkg::AluShra;
                    default:            AluSel = controlPkg::AluShl;
                endcase
            end
            controlPkg::OpAddi, controlPkg::OpAndi, controlPkg::OpOri: begin
                InstrClass  = controlPkg::ClsImmAlu;
                InstrLength = controlPkg::LenAlu;
                Legal       = 1'b1;
                case (OpCode)
                    controlPkg::OpAddi: AluSel = controlPkg::AluAdd;
                    controlPkg::OpAndi: AluSel = controlPkg::AluAnd;
                    default:            AluSel = controlPkg::AluOr;
                endcase
            end
            controlPkg::OpBr: begin
                InstrClass  = controlPkg::ClsBranch;
                AluSel      = controlPkg::AluAdd;   // pc plus displacement
                InstrLength = controlPkg::LenBranch;
                Legal       = 1'b1;
            end
            controlPkg::OpHalt: begin
                InstrClass  = controlPkg::ClsHalt;  // length one, sequencer parks it
                Legal       = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/stepSequencer.sv
`timescale 1ns/1ns

module stepSequencer (
    input  logic                              Clock,
    input  logic                              Reset,
    input  logic [controlPkg::ClassWidth-1:0] InstrClass,
    input  logic [controlPkg::StepWidth-1:0]  InstrLength,
    input  logic                              Legal,
    output logic [controlPkg::StepWidth-1:0]  Step,
    output logic                              InitStep,
    output logic                              Halted,
    output logic                              Running
);

    logic [controlPkg::StepWidth:0] lastStep;  // one bit wider so 3 + 5 - 1 fits
    logic                           atLast;
    logic                           endOfInstr;

    assign lastStep = {1'b0, controlPkg::StepExec} + {1'b0, InstrLength} - 1'b1;
    assign atLast   = (Step >= controlPkg::StepExec) && ({1'b0, Step} == lastStep);

    // an unknown opcode finishes in its first execute step
    assign endOfInstr = atLast || ((Step == controlPkg::StepExec) && !Legal);

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            Running  <= 1'b0;
            InitStep <= 1'b0;
            Halted   <= 1'b0;
            Step     <= controlPkg::StepFetch0;
        end else begin
            Running  <= 1'b1;
            InitStep <= ~Running;                           // single cycle right after reset
            if (!Running || InitStep || Halted) begin
                Step <= controlPkg::StepFetch0;             // hold until init is done
            end else if (endOfInstr) begin
                Step <= controlPkg::StepFetch0;             // back to fetch
            end else begin
                Step <= Step + 1'b1;
            end
            if ((Step == controlPkg::StepExec) && (InstrClass == controlPkg::ClsHalt)) begin
                Halted <= 1'b1;                             // sticky until reset
            end
        end
    end

    // step must stay inside the length decoded for the current instruction
    assert property (@(posedge Clock) disable iff (Reset)
        (Running && !InitStep && (Step >= controlPkg::StepExec)) |-> ({1'b0, Step} <= lastStep))
        else $error("step ran past end of instruction");

    // a halted unit parks at fetch0 and only reset releases it
    assert property (@(posedge Clock) disable iff (Reset)
        Halted |-> (Step == controlPkg::StepFetch0) ##1 Halted)
        else $error("halted unit left fetch0 or dropped without reset");

endmodule

// File: logic/controlSignalGen.sv
`timescale 1ns/1ns

module controlSignalGen (
    input  logic [controlPkg::StepWidth-1:0]  Step,
    input  logic                              InitStep,
    input  logic                              Halted,
    input  logic                              Running,
    input  logic [controlPkg::ClassWidth-1:0] InstrClass,
    input  logic [controlPkg::AluWidth-1:0]   AluSel,
    input  logic                              ConFf,
    output logic                              Gra,
    output logic                              Grb,
    output logic                              Grc,
    output logic                              Rin,
    output logic                              Rout,
    output logic                              Clear,
    output logic                              Read,
    output logic                              Write,
    output logic                              PcIn,
    output logic                              PcOut,
    output logic                              IncPc,
    output logic                              IrIn,
    output logic                              MarIn,
    output logic                              MdrIn,
    output logic                              MdrOut,
    output logic                              YIn,
    output logic                              ZIn,
    output logic                              ZLowOut,
    output logic                              ConstOut,
    output logic                              ConIn,
    output logic                              HaltOut,
    output logic [controlPkg::AluWidth-1:0]   AluOp
);

    always_comb begin
        Gra = 1'b0;      Grb = 1'b0;     Grc = 1'b0;
        Rin = 1'b0;      Rout = 1'b0;    Clear = 1'b0;
        Read = 1'b0;     Write = 1'b0;   PcIn = 1'b0;
        PcOut = 1'b0;    IncPc = 1'b0;   IrIn = 1'b0;
        MarIn = 1'b0;    MdrIn = 1'b0;   MdrOut = 1'b0;
        YIn = 1'b0;      ZIn = 1'b0;     ZLowOut = 1'b0;
        ConstOut = 1'b0; ConIn = 1'b0;   HaltOut = 1'b0;
        AluOp = controlPkg::AluNone;
        if (!Running) begin
            // held in reset, nothing driven
        end else if (Halted) begin
            HaltOut = 1'b1;                         // parked until reset
        end else if (InitStep) begin
            Clear = 1'b1;                           // clear regs, pc to zero
            PcIn  = 1'b1;
        end else begin
            case (Step)
                controlPkg::StepFetch0: begin
                    PcOut = 1'b1; MarIn = 1'b1; IncPc = 1'b1;   // pc to mar, bump pc
                end
                controlPkg::StepFetch1: begin
                    Read = 1'b1; MdrIn = 1'b1;                  // instruction into mdr
                end
                controlPkg::StepFetch2: begin
                    MdrOut = 1'b1; IrIn = 1'b1;                 // ir loads at end of cycle
                end
                3'd3: begin
                    case (InstrClass)
                        controlPkg::ClsRegAlu, controlPkg::ClsImmAlu,
                        controlPkg::ClsLoad, controlPkg::ClsStore: begin
                            Grb = 1'b1; Rout = 1'b1; YIn = 1'b1;  // rb into y
                        end
                        controlPkg::ClsBranch: begin
                            Gra = 1'b1; Rout = 1'b1; ConIn = 1'b1; // evaluate condition on ra
                        end
                        controlPkg::ClsHalt: HaltOut = 1'b1;
                        default: ;                            // illegal, idle step
                    endcase
                end
                3'd4: begin
                    case (InstrClass)
                        controlPkg::ClsRegAlu: begin
                            Grc = 1'b1; Rout = 1'b1; ZIn = 1'b1; AluOp = AluSel;
                        end
                        controlPkg::ClsImmAlu, controlPkg::ClsLoad, controlPkg::ClsStore: begin
                            ConstOut = 1'b1; ZIn = 1'b1; AluOp = AluSel;  // y op c
                        end
                        controlPkg::ClsBranch: begin
                            PcOut = 1'b1; YIn = 1'b1;
                        end
                        default: ;
                    endcase
                end
                3'd5: begin
                    case (InstrClass)
                        controlPkg::ClsRegAlu, controlPkg::ClsImmAlu: begin
                            ZLowOut = 1'b1; Gra = 1'b1; Rin = 1'b1;  // result to ra
                        end
                        controlPkg::ClsLoad, controlPkg::ClsStore: begin
                            ZLowOut = 1'b1; MarIn = 1'b1;           // effective address
                        end
                        controlPkg::ClsBranch: begin
                            ConstOut = 1'b1; ZIn = 1'b1; AluOp = AluSel;  // branch target
                        end
                        default: ;
                    endcase
                end
                3'd6: begin
                    case (InstrClass)
                        controlPkg::ClsLoad: begin
                            Read = 1'b1; MdrIn = 1'b1;
                        end
                        controlPkg::ClsStore: begin
                            Gra = 1'b1; Rout = 1'b1; MdrIn = 1'b1;  // store data
                        end
                        controlPkg::ClsBranch: begin
                            ZLowOut = ConFf;                        // taken, target on bus
                            IncPc   = ~ConFf;                       // not taken
                        end
                        default: ;
                    endcase
                end
                default: begin
                    case (InstrClass)
                        controlPkg::ClsLoad: begin
                            MdrOut = 1'b1; Gra = 1'b1; Rin = 1'b1;
                        end
                        controlPkg::ClsStore:  Write = 1'b1;
                        controlPkg::ClsBranch: PcIn = ConFf;        // commit taken branch
                        default: ;
                    endcase
                end
            endcase
        end
    end

    always_comb begin
        assert final ($onehot0({Rout, PcOut, MdrOut, ZLowOut, ConstOut}))
            else $error("bus driven by more than one source");
        assert final (!(Read && Write))
            else $error("read and write together");
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
    input  logic                              Clock,
    input  logic                              Reset,
    input  logic [controlPkg::InstrWidth-1:0] Ir,
    input  logic                              ConFf,
    output logic                              Gra,
    output logic                              Grb,
    output logic                              Grc,
    output logic                              Rin,
    output logic                              Rout,
    output logic                              Clear,
    output logic                              Read,
    output logic                              Write,
    output logic                              PcIn,
    output logic                              PcOut,
    output logic                              IncPc,
    output logic                              IrIn,
    output logic                              MarIn,
    output logic                              MdrIn,
    output logic                              MdrOut,
    output logic                              YIn,
    output logic                              ZIn,
    output logic                              ZLowOut,
    output logic                              ConstOut,
    output logic                              ConIn,
    output logic                              HaltOut,
    output logic [controlPkg::AluWidth-1:0]   AluOp
);

    logic [controlPkg::OpWidth-1:0]    opCode;
    logic [controlPkg::ClassWidth-1:0] instrClass;
    logic [controlPkg::AluWidth-1:0]   aluSel;
    logic [controlPkg::StepWidth-1:0]  instrLength;
    logic                              legal;
    logic [controlPkg::StepWidth-1:0]  step;
    logic                              initStep;
    logic                              halted;
    logic                              running;

    assign opCode = Ir[controlPkg::OpMsb -: controlPkg::OpWidth];  // top five bits

    opcodeDecoder decoder (
        .OpCode(opCode), .InstrClass(instrClass), .AluSel(aluSel),
        .InstrLength(instrLength), .Legal(legal)
    );

    stepSequencer sequencer (
        .Clock(Clock), .Reset(Reset), .InstrClass(instrClass),
        .InstrLength(instrLength), .Legal(legal), .Step(step),
        .InitStep(initStep), .Halted(halted), .Running(running)
    );

    controlSignalGen signalGen (
        .Step(step), .InitStep(initStep), .Halted(halted), .Running(running),
        .InstrClass(instrClass), .AluSel(aluSel), .ConFf(ConFf),
        .Gra(Gra), .Grb(Grb), .Grc(Grc), .Rin(Rin), .Rout(Rout),
        .Clear(Clear), .Read(Read), .Write(Write), .PcIn(PcIn),
        .PcOut(PcOut), .IncPc(IncPc), .IrIn(IrIn), .MarIn(MarIn),
        .MdrIn(MdrIn), .MdrOut(MdrOut), .YIn(YIn), .ZIn(ZIn),
        .ZLowOut(ZLowOut), .ConstOut(ConstOut), .ConIn(ConIn),
        .HaltOut(HaltOut), .AluOp(AluOp)
    );

endmodule

// File: test/controlUnitTable.svh
// one row per instruction, applied in order, halt must stay last
// columns: opCode, conFf, cycles, aluOp, reads, writes, pcLoads, consts, incs, busy
typedef struct packed {
    logic [controlPkg::OpWidth-1:0]  opCode;
    logic                            conFf;    // condition flag for the branch
    logic [3:0]                      cycles;   // fetch0 to next fetch0, halt uses watch window
    logic [controlPkg::AluWidth-1:0] aluOp;    // AluOp while ZIn is high
    logic [1:0]                      reads;    // Read pulses, fetch included
    logic [1:0]                      writes;
    logic [1:0]                      pcLoads;  // PcIn pulses after fetch
    logic [1:0]                      consts;   // ConstOut pulses
    logic [1:0]                      incs;     // IncPc pulses, fetch included
    logic [3:0]                      busy;     // execute cycles with any strobe
} rowEntry;

localparam int NumRows = 20;

rowEntry rows [NumRows] = '{
    '{controlPkg::OpAdd,  1'b0, 4'd6,  controlPkg::AluAdd,  2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd3},
    '{controlPkg::OpSub,  1'b0, 4'd6,  controlPkg::AluSub,  2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd3},
    '{controlPkg::OpAnd,  1'b1, 4'd6,  controlPkg::AluAnd,  2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd3},
    '{controlPkg::OpOr,   1'b0, 4'd6,  controlPkg::AluOr,   2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd3},
    '{controlPkg::OpRor,  1'b0, 4'd6,  controlPkg::AluRor,  2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd3},
    '{controlPkg::OpRol,  1'b1, 4'd6,  controlPkg::AluRol,  2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd3},
    '{controlPkg::OpShr,  1'b0, 4'd6,  controlPkg::AluShr,  2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd3},
    '{controlPkg::OpShra, 1'b0, 4'd6,  controlPkg::AluShra, 2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd3},
    '{controlPkg::OpShl,  1'b0, 4'd6,  controlPkg::AluShl,  2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd3},
    '{controlPkg::OpAddi, 1'b0, 4'd6,  controlPkg::AluAdd,  2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 4'd3},
    '{controlPkg::OpAndi, 1'b1, 4'd6,  controlPkg::AluAnd,  2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 4'd3},
    '{controlPkg::OpOri,  1'b0, 4'd6,  controlPkg::AluOr,   2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 4'd3},
    '{controlPkg::OpLd,   1'b0, 4'd8,  controlPkg::AluAdd,  2'd2, 2'd0, 2'd0, 2'd1, 2'd1, 4'd5},
    '{5'b01111,           1'b0, 4'd4,  controlPkg::AluNone, 2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd0},
    '{controlPkg::OpLdi,  1'b1, 4'd8,  controlPkg::AluAdd,  2'd2, 2'd0, 2'd0, 2'd1, 2'd1, 4'd5},
    '{controlPkg::OpSt,   1'b0, 4'd8,  controlPkg::AluAdd,  2'd1, 2'd1, 2'd0, 2'd1, 2'd1, 4'd5},
    '{controlPkg::OpBr,   1'b1, 4'd8,  controlPkg::AluAdd,  2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 4'd5},
    '{controlPkg::OpBr,   1'b0, 4'd8,  controlPkg::AluAdd,  2'd1, 2'd0, 2'd0, 2'd1, 2'd2, 4'd4},
    '{5'b11000,           1'b1, 4'd4,  controlPkg::AluNone, 2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd0},
    '{controlPkg::OpHalt, 1'b0, 4'd14, controlPkg::AluNone, 2'd1, 2'd0, 2'd0, 2'd0, 2'd1, 4'd11}
};

// File: test/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb;

    localparam int ResetCycles = 8;

    logic                              Clock;
    logic                              Reset;
    logic [controlPkg::InstrWidth-1:0] Ir;
    logic                              ConFf;
    logic Gra, Grb, Grc, Rin, Rout, Clear, Read, Write, PcIn, PcOut, IncPc;
    logic IrIn, MarIn, MdrIn, MdrOut, YIn, ZIn, ZLowOut, ConstOut, ConIn, HaltOut;
    logic [controlPkg::AluWidth-1:0]   AluOp;

    `include "controlUnitTable.svh"

    logic                            irLoad;       // IrIn seen in the cycle just sampled
    int                              cycleCount;
    int                              timeoutLimit;
    int readCount, writeCount, pcLoadCount, constCount, incCount, busyCount;
    logic [controlPkg::AluWidth-1:0] aluSeen;      // AluOp caught in the ZIn step

    controlUnit UUT (
        .Clock(Clock), .Reset(Reset), .Ir(Ir), .ConFf(ConFf),
        .Gra(Gra), .Grb(Grb), .Grc(Grc), .Rin(Rin), .Rout(Rout),
        .Clear(Clear), .Read(Read), .Write(Write), .PcIn(PcIn),
        .PcOut(PcOut), .IncPc(IncPc), .IrIn(IrIn), .MarIn(MarIn),
        .MdrIn(MdrIn), .MdrOut(MdrOut), .YIn(YIn), .ZIn(ZIn),
        .ZLowOut(ZLowOut), .ConstOut(ConstOut), .ConIn(ConIn),
        .HaltOut(HaltOut), .AluOp(AluOp)
    );

    always #5 Clock = ~Clock;                      // 10 ns period

    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            $display("run timed out after %0d cycles, the table never finished", cycleCount);
            abortRun();
        end
    end

    task automatic abortRun();
        $display(">>> FAIL");
        $fatal(1, "stopping on first failure");
    endtask

    task automatic checkValue(input string what, input int got, input int expected);
        if (got !== expected) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            abortRun();
        end
    endtask

    // every strobe except HaltOut
    function automatic logic anyStrobe();
        return Gra | Grb | Grc | Rin | Rout | Clear | Read | Write | PcIn | PcOut | IncPc
            | IrIn | MarIn | MdrIn | MdrOut | YIn | ZIn | ZLowOut | ConstOut | ConIn;
    endfunction

    // one clock, inputs moved 1 ns after the edge, outputs read at the falling edge
    task automatic stepClock(input int row);
        logic [31:0] rnd;
        @(posedge Clock);
        #1;
        if (irLoad) begin                          // ir loaded at this edge
            rnd   = $urandom();
            Ir    = {rows[row].opCode, rnd[controlPkg::OpMsb-controlPkg::OpWidth:0]};
            ConFf = rows[row].conFf;
        end
        @(negedge Clock);
        irLoad = IrIn;
    endtask

    // checks and counts for cycle cyc of the current instruction, 1 is fetch0
    task automatic tally(input int row, input int cyc);
        logic parked;
        parked = (rows[row].opCode == controlPkg::OpHalt) && (cyc > 3);
        if (cyc == 1)
            checkValue("fetch0 IncPc", IncPc, 1);
        if (cyc == 2)
            checkValue("fetch1 Read and MdrIn", {Read, MdrIn}, 2'b11);
        if (cyc == 3)
            checkValue("fetch2 MdrOut and IrIn", {MdrOut, IrIn}, 2'b11);
        readCount   += Read;
        writeCount  += Write;
        constCount  += ConstOut;
        incCount    += IncPc;
        if (cyc > 3) begin
            pcLoadCount += PcIn;                   // only execute steps load pc
            if (anyStrobe() || HaltOut)
                busyCount++;
        end
        if (ZIn)
            aluSeen = AluOp;
        else
            checkValue("AluOp outside the ALU step", AluOp, controlPkg::AluNone);
        checkValue("HaltOut", HaltOut, parked);
        if (parked) begin
            checkValue("MarIn while halted", MarIn, 0);
            checkValue("strobes beside HaltOut", anyStrobe(), 0);
        end
    endtask

    initial begin
        int   row;
        int   cyc;
        logic done;
        Clock      = 1'b0;
        Reset      = 1'b1;
        Ir         = '0;
        ConFf      = 1'b0;
        irLoad     = 1'b0;
        cycleCount = 0;
        void'($urandom(32'h3d84_2695));
        timeoutLimit = 20;                         // margin covers reset and init
        for (row = 0; row < NumRows; row++)
            timeoutLimit += rows[row].cycles;

        repeat (ResetCycles - 1) @(posedge Clock);
        @(negedge Clock);
        checkValue("strobes in reset", anyStrobe() | HaltOut, 0);
        checkValue("AluOp in reset", AluOp, controlPkg::AluNone);
        @(posedge Clock);
        #1 Reset = 1'b0;

        stepClock(0);                              // init step
        checkValue("init Clear and PcIn", {Clear, PcIn}, 2'b11);
        stepClock(0);
        checkValue("first fetch0", {PcOut, MarIn, IncPc}, 3'b111);

        for (row = 0; row < NumRows; row++) begin
            readCount   = 0;
            writeCount  = 0;
            pcLoadCount = 0;
            constCount  = 0;
            incCount    = 0;
            busyCount   = 0;
            aluSeen     = controlPkg::AluNone;
            cyc         = 1;
            tally(row, cyc);                       // fetch0 already sampled
            done = 1'b0;
            while (!done) begin
                if ((rows[row].opCode == controlPkg::OpHalt) && (cyc == rows[row].cycles)) begin
                    done = 1'b1;                   // watch window over
                end else begin
                    stepClock(row);
                    if ((rows[row].opCode != controlPkg::OpHalt) && PcOut && MarIn) begin
                        done = 1'b1;               // next fetch0 reached
                    end else begin
                        cyc++;
                        tally(row, cyc);
                    end
                end
            end
            checkValue($sformatf("row %0d cycles", row), cyc, rows[row].cycles);
            checkValue($sformatf("row %0d AluOp", row), aluSeen, rows[row].aluOp);
            checkValue($sformatf("row %0d Read pulses", row), readCount, rows[row].reads);
            checkValue($sformatf("row %0d Write pulses", row), writeCount, rows[row].writes);
            checkValue($sformatf("row %0d PcIn pulses", row), pcLoadCount, rows[row].pcLoads);
            checkValue($sformatf("row %0d ConstOut pulses", row), constCount, rows[row].consts);
            checkValue($sformatf("row %0d IncPc pulses", row), incCount, rows[row].incs);
            checkValue($sformatf("row %0d busy cycles", row), busyCount, rows[row].busy);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: tb.f
+incdir+test
logic/controlPkg.sv
logic/opcodeDecoder.sv
logic/stepSequencer.sv
logic/controlSignalGen.sv
logic/controlUnit.sv
test/controlUnitTb.sv
